/* design/csr_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module csr_file (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             csr_we,
    input  wire logic [11:0]      csr_waddr,
    input  wire logic [`XLEN-1:0] csr_wdata,
    input  wire logic             ecall_taken,
    output logic      [`XLEN-1:0] mstatus,
    output logic      [`XLEN-1:0] mtvec,
    output logic      [`XLEN-1:0] mepc,
    output logic      [`XLEN-1:0] mcause
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else begin
            if (csr_we) begin
                case (csr_waddr)
                    `CSR_MSTATUS: mstatus <= csr_wdata;
                    `CSR_MTVEC:   mtvec   <= csr_wdata;
                    `CSR_MEPC:    mepc    <= csr_wdata;
                    `CSR_MCAUSE:  mcause  <= csr_wdata;
                    default: ;
                endcase
            end
            // ecall writes mepc through the port and the cause here
            if (ecall_taken) begin
                mcause <= `XLEN'(`ECALL_CAUSE);
            end
        end
    end

    // operand_mux only raises a write after a successful address decode
    a_waddr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        csr_we |-> csr_waddr inside {`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE}
    ) else $error("csr_file: write to unknown CSR %0d", csr_waddr);

endmodule

`default_nettype wire

/* design/exec_alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module exec_alu
    import exec_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             issue_valid,
    input  wire issue_pkt_t       issue_pkt,
    input  wire logic [`XLEN-1:0] src1,
    input  wire logic [`XLEN-1:0] src2,
    output logic                  alu_valid,
    output exec_res_t             alu_res
);

    logic [`XLEN-1:0] result;
    logic [5:0]       shamt;

    assign shamt = src2[5:0];   // rv64 shift amount

    always_comb begin
        case (issue_pkt.op)
            ADD:     result = src1 + src2;
            SUB:     result = src1 - src2;
            AND:     result = src1 & src2;
            OR:      result = src1 | src2;
            XOR:     result = src1 ^ src2;
            SLL:     result = src1 << shamt;
            SRL:     result = src1 >> shamt;
            SRA:     result = $signed(src1) >>> shamt;
            SLT:     result = {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            SLTU:    result = {{(`XLEN-1){1'b0}}, src1 < src2};
            PASS2:   result = src2;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue_valid;
        end
    end

    // payload follows valid
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            alu_res.tag     <= issue_pkt.tag;
            alu_res.rd      <= issue_pkt.rd;
            alu_res.rd_data <= result;
        end
    end

    a_op_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        alu_valid |-> $past(issue_pkt.op) inside {ADD, SUB, AND, OR, XOR, SLL, SRL,
                                                  SRA, SLT, SLTU, PASS2}
    ) else $error("exec_alu: result from undefined op");

endmodule

`default_nettype wire

/* design/exec_defines.svh */
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// datapath width
`define XLEN 64

// machine CSR addresses
`define CSR_MSTATUS 12'd768
`define CSR_MTVEC   12'd773
`define CSR_MEPC    12'd833
`define CSR_MCAUSE  12'd834

// environment call from M-mode
`define ECALL_CAUSE 11

`define QUEUE_DEPTH 4   // result slots and the issuer's starting credits
`define OUT_CREDITS 2   // writeback buffer size after reset

`endif

/* design/exec_pkg.sv */
`default_nettype none

`include "exec_defines.svh"

package exec_pkg;

    typedef enum logic [2:0] {
        SRC_REG     = 3'd0,    // rs1, rs2
        SRC_IMM     = 3'd1,    // rs1, imm
        SRC_FOUR_PC = 3'd2,    // 4, pc
        SRC_IMM_PC  = 3'd3,    // imm, pc
        SRC_CSRRS   = 3'd4,    // rs1, csr
        SRC_ECALL   = 3'd5     // pc, mtvec
    } alu_src_e;

    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        AND   = 4'd2,
        OR    = 4'd3,
        XOR   = 4'd4,
        SLL   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        SLT   = 4'd8,
        SLTU  = 4'd9,
        PASS2 = 4'd10          // src2 straight through
    } alu_op_e;

    typedef struct packed {
        logic [7:0]       tag;
        logic [4:0]       rd;
        alu_src_e         src_sel;
        alu_op_e          op;
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] pc;
        logic [11:0]      csr_addr;
    } issue_pkt_t;

    typedef struct packed {
        logic [7:0]       tag;
        logic [4:0]       rd;
        logic [`XLEN-1:0] rd_data;
    } exec_res_t;

endpackage

`default_nettype wire

/* design/exec_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module exec_top
    import exec_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       issue_valid,
    input  wire issue_pkt_t issue_pkt,
    output logic            issue_credit,
    output logic            res_valid,
    output exec_res_t       res,
    input  wire logic       out_credit
);

    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;
    logic             csr_we;
    logic [11:0]      csr_waddr;
    logic [`XLEN-1:0] csr_wdata;
    logic             ecall_taken;
    logic [`XLEN-1:0] mstatus;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;
    logic             alu_valid;
    exec_res_t        alu_res;

    operand_mux operand_mux_i (
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .mstatus     (mstatus),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mcause      (mcause),
        .src1        (src1),
        .src2        (src2),
        .csr_we      (csr_we),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata),
        .ecall_taken (ecall_taken)
    );

    csr_file csr_file_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_we      (csr_we),
        .csr_waddr   (csr_waddr),
        .csr_wdata   (csr_wdata),
        .ecall_taken (ecall_taken),
        .mstatus     (mstatus),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mcause      (mcause)
    );

    exec_alu exec_alu_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_pkt   (issue_pkt),
        .src1        (src1),
        .src2        (src2),
        .alu_valid   (alu_valid),
        .alu_res     (alu_res)
    );

    result_queue result_queue_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .alu_valid    (alu_valid),
        .alu_res      (alu_res),
        .out_credit   (out_credit),
        .res_valid    (res_valid),
        .res          (res),
        .issue_credit (issue_credit)
    );

endmodule

`default_nettype wire

/* design/operand_mux.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module operand_mux
    import exec_pkg::*;
(
    input  wire logic             issue_valid,
    input  wire issue_pkt_t       issue_pkt,
    input  wire logic [`XLEN-1:0] mstatus,
    input  wire logic [`XLEN-1:0] mtvec,
    input  wire logic [`XLEN-1:0] mepc,
    input  wire logic [`XLEN-1:0] mcause,
    output logic      [`XLEN-1:0] src1,
    output logic      [`XLEN-1:0] src2,
    output logic                  csr_we,
    output logic      [11:0]      csr_waddr,
    output logic      [`XLEN-1:0] csr_wdata,
    output logic                  ecall_taken
);

    logic             csr_hit;
    logic [`XLEN-1:0] csr_old;

    // CSR read port
    always_comb begin
        csr_hit = 1'b1;
        csr_old = '0;
        case (issue_pkt.csr_addr)
            `CSR_MSTATUS: csr_old = mstatus;
            `CSR_MTVEC:   csr_old = mtvec;
            `CSR_MEPC:    csr_old = mepc;
            `CSR_MCAUSE:  csr_old = mcause;
            default:      csr_hit = 1'b0;   // outside the kept CSRs
        endcase
    end

    always_comb begin
        src1        = issue_pkt.rs1_data;   // default reg1
        src2        = issue_pkt.rs2_data;   // default reg2
        csr_we      = 1'b0;
        csr_waddr   = issue_pkt.csr_addr;
        csr_wdata   = '0;
        ecall_taken = 1'b0;
        case (issue_pkt.src_sel)
            SRC_REG: ;
            SRC_IMM:
                src2 = issue_pkt.imm;
            SRC_FOUR_PC: begin
                src1 = `XLEN'd4;            // return address
                src2 = issue_pkt.pc;
            end
            SRC_IMM_PC: begin
                src1 = issue_pkt.imm;
                src2 = issue_pkt.pc;
            end
            SRC_CSRRS: begin
                if (csr_hit) begin
                    src2      = csr_old;    // rd gets old value via PASS2
                    csr_we    = issue_valid;
                    csr_wdata = issue_pkt.rs1_data | csr_old;
                end
            end
            SRC_ECALL: begin
                src1        = issue_pkt.pc;
                src2        = mtvec;        // trap target into rd
                csr_we      = issue_valid;
                csr_waddr   = `CSR_MEPC;
                csr_wdata   = issue_pkt.pc;
                ecall_taken = issue_valid;
            end
            default: ;
        endcase
    end

    // valid issue needs a decodable source select
    always_comb begin
        if (issue_valid) begin
            assert final (issue_pkt.src_sel inside {SRC_REG, SRC_IMM, SRC_FOUR_PC,
                                                    SRC_IMM_PC, SRC_CSRRS, SRC_ECALL})
            else $error("operand_mux: undefined src_sel %0d", issue_pkt.src_sel);
        end
    end

endmodule

`default_nettype wire

/* design/result_queue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module result_queue
    import exec_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      alu_valid,
    input  wire exec_res_t alu_res,
    input  wire logic      out_credit,
    output logic           res_valid,
    output exec_res_t      res,
    output logic           issue_credit
);

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`OUT_CREDITS + 1) + 1;   // spare bit so overrun is visible

    exec_res_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] out_cnt;   // downstream credits held
    logic             full;
    logic             pop;

    assign full         = (count == CNT_W'(DEPTH));
    assign pop          = (count != '0) && (out_cnt != '0);
    assign res_valid    = pop;
    assign res          = mem[rd_ptr];
    assign issue_credit = pop;      // freed slot goes back upstream as a credit

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            mem[wr_ptr] <= alu_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            out_cnt <= CRD_W'(`OUT_CREDITS);
        end else begin
            if (alu_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({alu_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            case ({out_credit, pop})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: ;
            endcase
        end
    end

    // issuer credits must keep the ALU stage plus queue within DEPTH
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(alu_valid && full)
    ) else $error("result_queue: write while full");

    // writeback returned more credits than it was given
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_cnt <= CRD_W'(`OUT_CREDITS)
    ) else $error("result_queue: downstream credits above %0d", `OUT_CREDITS);

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/exec_pkg.sv
design/operand_mux.sv
design/csr_file.sv
design/exec_alu.sv
design/result_queue.sv
design/exec_top.sv
test/exec_checker.sv
test/exec_tb.sv

/* test/exec_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module exec_checker
    import exec_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       issue_valid,
    input  wire issue_pkt_t issue_pkt,
    input  wire logic       issue_credit,
    input  wire logic       res_valid,
    input  wire exec_res_t  res,
    input  wire logic       out_credit,
    output int              data_errors,
    output int              proto_errors,
    output int              results_seen
);

    logic [`XLEN-1:0] csr_m [4];   // mstatus, mtvec, mepc, mcause
    exec_res_t        expect_q [$];
    exec_res_t        want;
    int               in_flight;    // issues whose credit has not come back
    int               wb_credits;   // downstream credits the DUT holds
    int               err_data  = 0;
    int               err_proto = 0;
    int               seen      = 0;

    function automatic int csr_index(logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS: return 0;
            `CSR_MTVEC:   return 1;
            `CSR_MEPC:    return 2;
            `CSR_MCAUSE:  return 3;
            default:      return -1;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] alu_model(alu_op_e op, logic [`XLEN-1:0] a,
                                                    logic [`XLEN-1:0] b);
        logic signed [`XLEN-1:0] sa;
        logic signed [`XLEN-1:0] sb;
        int unsigned             sh;
        sa = a;
        sb = b;
        sh = b[5:0];
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << sh;
            SRL:     return a >> sh;
            SRA:     return sa >>> sh;
            SLT:     return (sa < sb) ? 1 : 0;
            SLTU:    return (a < b) ? 1 : 0;
            PASS2:   return b;
            default: return 'x;
        endcase
    endfunction

    task automatic model_issue(issue_pkt_t p);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        int               idx;
        exec_res_t        r;
        a   = p.rs1_data;
        b   = p.rs2_data;
        idx = csr_index(p.csr_addr);
        case (p.src_sel)
            SRC_IMM:     b = p.imm;
            SRC_FOUR_PC: begin
                a = 4;
                b = p.pc;
            end
            SRC_IMM_PC: begin
                a = p.imm;
                b = p.pc;
            end
            SRC_CSRRS: begin
                if (idx >= 0) begin   // unknown address keeps rs2
                    b          = csr_m[idx];
                    csr_m[idx] = p.rs1_data | csr_m[idx];
                end
            end
            SRC_ECALL: begin
                a        = p.pc;
                b        = csr_m[1];
                csr_m[2] = p.pc;
                csr_m[3] = `ECALL_CAUSE;
            end
            default: ;
        endcase
        r.tag     = p.tag;
        r.rd      = p.rd;
        r.rd_data = alu_model(p.op, a, b);
        expect_q.push_back(r);
    endtask

    task automatic compare_field(string name, logic [`XLEN-1:0] exp_val,
                                 logic [`XLEN-1:0] got_val);
        if (got_val !== exp_val) begin
            $display("FAILED at %0t: %s expected %0h got %0h", $time, name, exp_val, got_val);
            err_data++;
        end
    endtask

    task automatic protocol_error(string what);
        $display("protocol error at %0t: %s", $time, what);
        err_proto++;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            csr_m      = '{default: '0};
            expect_q.delete();
            in_flight  = 0;
            wb_credits = `OUT_CREDITS;
        end else begin
            if (res_valid) begin
                if (wb_credits == 0) protocol_error("result sent without a downstream credit");
                else wb_credits--;
                if (expect_q.size() == 0) begin
                    protocol_error("result arrived with no issue outstanding");
                end else begin
                    want = expect_q.pop_front();   // results stay in issue order
                    compare_field("res.tag", want.tag, res.tag);
                    compare_field("res.rd", want.rd, res.rd);
                    compare_field("res.rd_data", want.rd_data, res.rd_data);
                end
                seen++;
            end
            if (out_credit) wb_credits++;
            if (issue_credit != res_valid) protocol_error("issue_credit does not match a pop");
            if (issue_credit) begin
                if (in_flight == 0) protocol_error("issue_credit with no credit outstanding");
                else in_flight--;
            end
            if (issue_valid) begin
                in_flight++;
                model_issue(issue_pkt);
            end
        end
        data_errors  <= err_data;
        proto_errors <= err_proto;
        results_seen <= seen;
    end

endmodule

`default_nettype wire

/* test/exec_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module exec_tb
    import exec_pkg::*;
();

    localparam int NUM_PKTS    = 400;
    localparam int CYCLE_LIMIT = NUM_PKTS * 8 + 200;

    logic       clk;
    logic       rst_n;
    logic       issue_valid;
    issue_pkt_t issue_pkt;
    logic       issue_credit;
    logic       res_valid;
    exec_res_t  res;
    logic       out_credit;

    int issue_credits;   // issuer's own count
    int sent;
    int wb_pending;      // results held by writeback
    int cycles    = 0;
    bit timed_out = 1'b0;
    int data_errors;
    int proto_errors;
    int results_seen;

    exec_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_pkt    (issue_pkt),
        .issue_credit (issue_credit),
        .res_valid    (res_valid),
        .res          (res),
        .out_credit   (out_credit)
    );

    exec_checker checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_pkt    (issue_pkt),
        .issue_credit (issue_credit),
        .res_valid    (res_valid),
        .res          (res),
        .out_credit   (out_credit),
        .data_errors  (data_errors),
        .proto_errors (proto_errors),
        .results_seen (results_seen)
    );

    always #4 clk = ~clk;

    function automatic issue_pkt_t random_packet(int idx);
        issue_pkt_t p;
        p.tag      = idx[7:0];
        p.rd       = 5'($urandom);
        p.rs1_data = {$urandom, $urandom};
        p.rs2_data = {$urandom, $urandom};
        p.imm      = {$urandom, $urandom};
        p.pc       = {$urandom, $urandom} & ~64'h3;
        p.src_sel  = alu_src_e'($urandom_range(5));
        p.op       = alu_op_e'($urandom_range(10));
        case ($urandom_range(9))   // mostly the four kept CSRs
            0, 1:    p.csr_addr = `CSR_MSTATUS;
            2, 3:    p.csr_addr = `CSR_MTVEC;
            4, 5:    p.csr_addr = `CSR_MEPC;
            6, 7:    p.csr_addr = `CSR_MCAUSE;
            default: p.csr_addr = 12'($urandom);
        endcase
        if (p.src_sel inside {SRC_FOUR_PC, SRC_IMM_PC}) p.op = ADD;
        if (p.src_sel inside {SRC_CSRRS, SRC_ECALL}) p.op = PASS2;
        if (p.src_sel == SRC_CSRRS && $urandom_range(1) == 0) begin
            p.rs1_data = `XLEN'(1) << $urandom_range(63);   // sparse set mask
        end
        return p;
    endfunction

    task automatic drive_issue();
        bit go;
        go = (issue_credits > 0) && (sent < NUM_PKTS) && ($urandom_range(3) != 0);
        if (go) begin
            issue_valid <= 1'b1;
            issue_pkt   <= random_packet(sent);
            issue_credits--;
            sent++;
        end else begin
            issue_valid <= 1'b0;
        end
        if (issue_credit) issue_credits++;
    endtask

    task automatic drive_credit();
        if (wb_pending > 0 && $urandom_range(3) != 0) begin
            out_credit <= 1'b1;
            wb_pending--;
        end else begin
            out_credit <= 1'b0;
        end
        if (res_valid) wb_pending++;
    endtask

    task automatic close_run();
        $display("results checked %0d of %0d, data errors %0d, protocol errors %0d",
                 results_seen, NUM_PKTS, data_errors, proto_errors);
        if (data_errors == 0 && proto_errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'h4e8b001f));
        clk           = 1'b0;
        rst_n         = 1'b0;
        issue_valid   = 1'b0;
        issue_pkt     = '0;
        out_credit    = 1'b0;
        issue_credits = `QUEUE_DEPTH;
        sent          = 0;
        wb_pending    = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        forever begin
            @(posedge clk);
            drive_issue();
            drive_credit();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (results_seen == NUM_PKTS) begin
            close_run();
        end else if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: %0d of %0d results arrived within %0d cycles",
                     results_seen, NUM_PKTS, CYCLE_LIMIT);
            timed_out = 1'b1;
            close_run();
        end
    end

endmodule

`default_nettype wire
